/* design/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;

    // ExcCode values as in the MIPS32 Cause register
    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_OV   = 5'd12
    } exc_code_t;

    // implemented register numbers
    localparam creg_addr_t CREG_BADVADDR = 5'd8;
    localparam creg_addr_t CREG_COUNT    = 5'd9;
    localparam creg_addr_t CREG_COMPARE  = 5'd11;
    localparam creg_addr_t CREG_STATUS   = 5'd12;
    localparam creg_addr_t CREG_CAUSE    = 5'd13;
    localparam creg_addr_t CREG_EPC      = 5'd14;
    localparam creg_addr_t CREG_CONFIG   = 5'd16;

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  IM;
        logic [4:0]  rsvd_lo;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    typedef struct packed {
        logic        BD;
        logic        TI;
        logic [13:0] rsvd_hi;
        logic [7:0]  IP;
        logic        rsvd_mid;
        exc_code_t   exccode;
        logic [1:0]  rsvd_lo;
    } cp0_cause_t;

    // MTC0 data seen in the layout of its target register
    typedef union packed {
        word_t       raw;
        cp0_status_t status;
        cp0_cause_t  cause;
    } cp0_word_u;

    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } cp0_write_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      in_delay_slot;
        logic      exc_valid;
        exc_code_t code;
        word_t     badvaddr;
    } commit_slot_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      in_delay_slot;
        exc_code_t code;
        word_t     badvaddr;
    } exception_t;

    typedef struct packed {
        word_t       badvaddr;
        word_t       count;
        word_t       compare;
        cp0_status_t status;
        cp0_cause_t  cause;
        word_t       epc;
        word_t       config_;
    } cp0_regs_t;

    localparam cp0_status_t CP0_INIT_STATUS  = '0;
    localparam word_t       CP0_CONFIG_VALUE = 32'h8000_0000;

endpackage

/* design/cp0.sv */
`timescale 1ns/1ps

module cp0 (
    input  logic                       clk,
    input  logic                       reset,
    input  mips_pkg::cp0_write_t [1:0] cwrite,
    input  mips_pkg::creg_addr_t [1:0] ra,
    output mips_pkg::word_t      [1:0] rd,
    input  logic                       is_eret,
    input  mips_pkg::exception_t       exception,
    input  logic                 [5:0] hw_int,
    output logic                       timer_interrupt,
    output mips_pkg::cp0_status_t      cp0_status,
    output mips_pkg::cp0_cause_t       cp0_cause,
    output mips_pkg::word_t            cp0_epc
);

    mips_pkg::cp0_regs_t regs;
    mips_pkg::cp0_regs_t regs_n;
    mips_pkg::cp0_word_u wdu;
    logic                count_tick;
    logic                compare_write;
    logic                addr_error;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{
                badvaddr: '0,
                count:    '0,
                compare:  '0,
                status:   mips_pkg::CP0_INIT_STATUS,
                cause:    '0,
                epc:      '0,
                config_:  mips_pkg::CP0_CONFIG_VALUE
            };
        end else begin
            regs <= regs_n;
        end
    end

    // count advances at half the clock rate
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_tick <= 1'b0;
        end else begin
            count_tick <= ~count_tick;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer_interrupt <= 1'b0;
        end else if (compare_write) begin
            timer_interrupt <= 1'b0;
        end else if (regs_n.count == regs_n.compare) begin
            timer_interrupt <= 1'b1;
        end
    end

    // MFC0 reads see only the old state
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            case (ra[p])
                mips_pkg::CREG_BADVADDR: rd[p] = regs.badvaddr;
                mips_pkg::CREG_COUNT:    rd[p] = regs.count;
                mips_pkg::CREG_COMPARE:  rd[p] = regs.compare;
                mips_pkg::CREG_STATUS:   rd[p] = regs.status;
                mips_pkg::CREG_CAUSE:    rd[p] = regs.cause;
                mips_pkg::CREG_EPC:      rd[p] = regs.epc;
                mips_pkg::CREG_CONFIG:   rd[p] = regs.config_;
                default:                 rd[p] = '0;
            endcase
        end
    end

    assign addr_error = (exception.code == mips_pkg::CODE_ADEL) ||
                        (exception.code == mips_pkg::CODE_ADES);

    always_comb begin
        regs_n        = regs;
        wdu           = '0;
        compare_write = 1'b0;

        regs_n.count = regs.count + {31'b0, count_tick};

        // port 1 first so port 0 wins a collision
        for (int p = 1; p >= 0; p--) begin
            wdu.raw = cwrite[p].wd;
            if (cwrite[p].wen) begin
                case (cwrite[p].addr)
                    mips_pkg::CREG_COUNT:   regs_n.count = wdu.raw;
                    mips_pkg::CREG_COMPARE: begin
                        regs_n.compare = wdu.raw;
                        compare_write  = 1'b1;
                    end
                    mips_pkg::CREG_STATUS: begin
                        regs_n.status.IM  = wdu.status.IM;
                        regs_n.status.EXL = wdu.status.EXL;
                        regs_n.status.IE  = wdu.status.IE;
                    end
                    mips_pkg::CREG_CAUSE:   regs_n.cause.IP[1:0] = wdu.cause.IP[1:0];
                    mips_pkg::CREG_EPC:     regs_n.epc = wdu.raw;
                    default: ;
                endcase
            end
        end

        // hardware lines with the timer ORed into IP7
        regs_n.cause.IP[7:2] = {hw_int[5] | timer_interrupt, hw_int[4:0]};
        regs_n.cause.TI      = timer_interrupt;

        if (exception.valid) begin
            // nested exception keeps the first EPC
            if (!regs.status.EXL) begin
                regs_n.cause.BD = exception.in_delay_slot;
                regs_n.epc      = exception.in_delay_slot ? exception.pc - 32'd4
                                                          : exception.pc;
            end
            regs_n.cause.exccode = exception.code;
            regs_n.status.EXL    = 1'b1;
            if (addr_error) begin
                regs_n.badvaddr = exception.badvaddr;
            end
        end else if (is_eret) begin
            if (regs.status.ERL) begin
                regs_n.status.ERL = 1'b0;
            end else begin
                regs_n.status.EXL = 1'b0;
            end
        end
    end

    assign cp0_status = regs.status;
    assign cp0_cause  = regs.cause;
    assign cp0_epc    = regs.epc;

endmodule

/* design/interrupt_ctrl.sv */
`timescale 1ns/1ps

module interrupt_ctrl (
    input  mips_pkg::cp0_status_t cp0_status,
    input  mips_pkg::cp0_cause_t  cp0_cause,
    output logic                  int_pending
);

    logic [7:0] masked_ip;
    logic       int_enabled;

    // IP already carries hw lines, timer and sw bits
    assign masked_ip = cp0_cause.IP & cp0_status.IM;

    // blocked while at exception or error level
    assign int_enabled = cp0_status.IE &
                         ~cp0_status.EXL &
                         ~cp0_status.ERL;

    assign int_pending = int_enabled & (|masked_ip);

endmodule

/* design/exception_unit.sv */
`timescale 1ns/1ps

module exception_unit #(
    parameter logic [31:0] EXC_VECTOR = 32'hBFC0_0380
) (
    input  mips_pkg::commit_slot_t [1:0] slot,
    input  logic                         int_pending,
    input  logic                         is_eret,
    input  mips_pkg::word_t              cp0_epc,
    output mips_pkg::exception_t         exception,
    output logic                         redirect_valid,
    output mips_pkg::word_t              redirect_pc
);

    function automatic mips_pkg::exception_t make_record(
        input mips_pkg::commit_slot_t s,
        input mips_pkg::exc_code_t    code
    );
        mips_pkg::exception_t r;
        r.valid         = 1'b1;
        r.pc            = s.pc;
        r.in_delay_slot = s.in_delay_slot;
        r.code          = code;
        r.badvaddr      = s.badvaddr;
        return r;
    endfunction

    logic any_valid;
    logic slot0_fault;
    logic slot1_fault;

    assign any_valid   = slot[0].valid | slot[1].valid;
    assign slot0_fault = slot[0].valid & slot[0].exc_valid;
    assign slot1_fault = slot[1].valid & slot[1].exc_valid;

    // interrupt first and then the older slot
    always_comb begin
        exception = '0;
        if (int_pending && any_valid) begin
            if (slot[0].valid) begin
                exception = make_record(slot[0], mips_pkg::CODE_INT);
            end else begin
                exception = make_record(slot[1], mips_pkg::CODE_INT);
            end
        end else if (slot0_fault) begin
            exception = make_record(slot[0], slot[0].code);
        end else if (slot1_fault) begin
            exception = make_record(slot[1], slot[1].code);
        end
    end

    assign redirect_valid = exception.valid | is_eret;
    assign redirect_pc    = exception.valid ? EXC_VECTOR : cp0_epc;

endmodule

/* design/cp0_subsystem.sv */
`timescale 1ns/1ps

module cp0_subsystem #(
    parameter logic [31:0] EXC_VECTOR = 32'hBFC0_0380
) (
    input  logic                         clk,
    input  logic                         reset,
    input  mips_pkg::cp0_write_t   [1:0] cwrite,
    input  mips_pkg::creg_addr_t   [1:0] ra,
    input  mips_pkg::commit_slot_t [1:0] slot,
    input  logic                         is_eret,
    input  logic                   [5:0] hw_int,
    output mips_pkg::word_t        [1:0] rd,
    output logic                         redirect_valid,
    output mips_pkg::word_t              redirect_pc,
    output logic                         timer_interrupt,
    output mips_pkg::cp0_status_t        cp0_status,
    output mips_pkg::cp0_cause_t         cp0_cause,
    output mips_pkg::word_t              cp0_epc
);

    logic                 int_pending;
    mips_pkg::exception_t exception;

    cp0 u_cp0 (
        .clk             (clk),
        .reset           (reset),
        .cwrite          (cwrite),
        .ra              (ra),
        .rd              (rd),
        .is_eret         (is_eret),
        .exception       (exception),
        .hw_int          (hw_int),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (cp0_status),
        .cp0_cause       (cp0_cause),
        .cp0_epc         (cp0_epc)
    );

    interrupt_ctrl u_interrupt_ctrl (
        .cp0_status  (cp0_status),
        .cp0_cause   (cp0_cause),
        .int_pending (int_pending)
    );

    exception_unit #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_exception_unit (
        .slot           (slot),
        .int_pending    (int_pending),
        .is_eret        (is_eret),
        .cp0_epc        (cp0_epc),
        .exception      (exception),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* testbench/cp0_checker.sv */
`timescale 1ns/1ps

module cp0_checker (
    input  logic                        clk,
    input  int                          vec_id,
    input  logic                  [7:0] kind,
    input  int                          timer_limit,
    input  mips_pkg::word_t       [1:0] rd,
    input  logic                        redirect_valid,
    input  mips_pkg::word_t             redirect_pc,
    input  logic                        timer_interrupt,
    input  mips_pkg::cp0_status_t       cp0_status,
    input  mips_pkg::cp0_cause_t        cp0_cause,
    input  mips_pkg::word_t             cp0_epc,
    input  mips_pkg::word_t             exp_rd0,
    input  mips_pkg::word_t             exp_rd1,
    input  logic                        exp_rv,
    input  mips_pkg::word_t             exp_rpc,
    input  mips_pkg::word_t             exp_status,
    input  mips_pkg::word_t             exp_cause,
    input  mips_pkg::word_t             cause_mask,
    input  mips_pkg::word_t             exp_epc,
    input  logic                        exp_timer,
    output int                          done_id,
    output int                          pass_count,
    output int                          fail_count
);

    int errors;

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %0t: vector %0d %s is %h, expected %h",
                     $time, vec_id, what, got, want);
            errors++;
        end
    endtask

    initial begin
        done_id    = 0;
        pass_count = 0;
        fail_count = 0;
    end

    always @(vec_id) begin
        int   cycles;
        logic fired;
        errors = 0;
        cycles = 0;
        fired  = 1'b0;
        // combinational outputs of the same cycle
        #2;
        compare_word("rd[0]", rd[0], exp_rd0);
        compare_word("rd[1]", rd[1], exp_rd1);
        compare_word("redirect_valid", {31'b0, redirect_valid}, {31'b0, exp_rv});
        compare_word("redirect_pc", redirect_pc, exp_rpc);
        if (kind == "T") begin
            while (!fired && cycles < timer_limit) begin
                @(posedge clk);
                #1;
                cycles++;
                fired = timer_interrupt;
            end
            if (!fired) begin
                $display("vector %0d: timer interrupt did not rise within %0d cycles",
                         vec_id, timer_limit);
                errors++;
            end else begin
                @(posedge clk);
                #1;
                compare_word("Cause IP7", {31'b0, cp0_cause.IP[7]}, 32'd1);
            end
        end else begin
            // register state after the edge
            @(posedge clk);
            #1;
            compare_word("Status", cp0_status, exp_status);
            compare_word("Cause", cp0_cause & cause_mask, exp_cause & cause_mask);
            compare_word("EPC", cp0_epc, exp_epc);
            compare_word("timer_interrupt", {31'b0, timer_interrupt}, {31'b0, exp_timer});
        end
        if (errors == 0) begin
            pass_count++;
            $display("vector %0d (%c) ok", vec_id, kind);
        end else begin
            fail_count++;
            $display("vector %0d (%c) failed with %0d mismatches", vec_id, kind, errors);
        end
        done_id = vec_id;
    end

endmodule

/* testbench/cp0_assertions.sv */
`timescale 1ns/1ps

module cp0_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  exc_valid,
    input logic                  timer_interrupt,
    input logic                  compare_write,
    input mips_pkg::cp0_status_t cp0_status
);

    // exception entry always raises EXL
    assert property (@(posedge clk) disable iff (reset) exc_valid |=> cp0_status.EXL)
        else $error("EXL not set one cycle after an exception");

    assert property (@(posedge clk) disable iff (reset)
        $fell(timer_interrupt) |-> $past(compare_write))
        else $error("timer interrupt dropped without a Compare write");

    // only IM, ERL, EXL and IE exist
    assert property (@(posedge clk) disable iff (reset)
        (cp0_status & 32'hFFFF_00F8) == 32'h0)
        else $error("reserved Status bits are not zero");

endmodule

bind cp0 cp0_assertions u_assertions (
    .clk             (clk),
    .reset           (reset),
    .exc_valid       (exception.valid),
    .timer_interrupt (timer_interrupt),
    .compare_write   (compare_write),
    .cp0_status      (cp0_status)
);

/* testbench/cp0_tb.sv */
`timescale 1ns/1ps

module cp0_tb;

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [4:0]  ra0;
        logic [4:0]  ra1;
        logic [31:0] rd0;
        logic [31:0] rd1;
        logic        rv;
        logic [31:0] rpc;
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] cause_mask;
        logic [31:0] epc;
        logic        timer;
    } vector_t;

    logic                         clk;
    logic                         reset;
    mips_pkg::cp0_write_t   [1:0] cwrite;
    mips_pkg::creg_addr_t   [1:0] ra;
    mips_pkg::commit_slot_t [1:0] slot;
    logic                         is_eret;
    logic                   [5:0] hw_int;
    mips_pkg::word_t        [1:0] rd;
    logic                         redirect_valid;
    mips_pkg::word_t              redirect_pc;
    logic                         timer_interrupt;
    mips_pkg::cp0_status_t        cp0_status;
    mips_pkg::cp0_cause_t         cp0_cause;
    mips_pkg::word_t              cp0_epc;

    vector_t vecs[$];
    vector_t cur;
    int      vec_id = 0;
    int      done_id;
    int      timer_limit = 0;
    int      pass_count;
    int      fail_count;
    int      load_errors = 0;
    bit      loaded = 1'b0;

    cp0_subsystem DUT (
        .clk(clk), .reset(reset), .cwrite(cwrite), .ra(ra), .slot(slot),
        .is_eret(is_eret), .hw_int(hw_int), .rd(rd), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc), .timer_interrupt(timer_interrupt),
        .cp0_status(cp0_status), .cp0_cause(cp0_cause), .cp0_epc(cp0_epc)
    );

    cp0_checker u_checker (
        .clk(clk), .vec_id(vec_id), .kind(cur.kind), .timer_limit(timer_limit),
        .rd(rd), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .timer_interrupt(timer_interrupt), .cp0_status(cp0_status),
        .cp0_cause(cp0_cause), .cp0_epc(cp0_epc),
        .exp_rd0(cur.rd0), .exp_rd1(cur.rd1), .exp_rv(cur.rv), .exp_rpc(cur.rpc),
        .exp_status(cur.status), .exp_cause(cur.cause), .cause_mask(cur.cause_mask),
        .exp_epc(cur.epc), .exp_timer(cur.timer),
        .done_id(done_id), .pass_count(pass_count), .fail_count(fail_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] writable_bits(input logic [4:0] addr);
        case (addr)
            mips_pkg::CREG_STATUS:  return 32'h0000_FF03;
            mips_pkg::CREG_CAUSE:   return 32'h0000_0300;
            mips_pkg::CREG_COUNT,
            mips_pkg::CREG_COMPARE,
            mips_pkg::CREG_EPC:     return 32'hFFFF_FFFF;
            default:                return 32'h0;
        endcase
    endfunction

    // read-only bits get random data
    function automatic logic [31:0] fill_fixed_bits(input logic [4:0] addr,
                                                    input logic [31:0] data);
        logic [31:0] keep;
        keep = writable_bits(addr);
        return (data & keep) | ($urandom & ~keep);
    endfunction

    task automatic clear_controls();
        cwrite  = '0;
        slot    = '0;
        is_eret = 1'b0;
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  k;
        logic [31:0] f [0:14];
        vector_t     v;
        fd = $fopen("testbench/cp0_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
            load_errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", k,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14]);
            if (n != 16) begin
                $display("malformed vector line: %s", line);
                load_errors++;
                continue;
            end
            v = '{kind: k, a: f[0], b: f[1], c: f[2], d: f[3], ra0: f[4][4:0],
                  ra1: f[5][4:0], rd0: f[6], rd1: f[7], rv: f[8][0], rpc: f[9],
                  status: f[10], cause: f[11], cause_mask: f[12], epc: f[13],
                  timer: f[14][0]};
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input vector_t v);
        ra[0] = v.ra0;
        ra[1] = v.ra1;
        case (v.kind)
            "W": cwrite[v.a[0]] = '{1'b1, v.b[4:0], fill_fixed_bits(v.b[4:0], v.c)};
            "D": begin
                cwrite[0] = '{1'b1, v.a[4:0], v.b};
                cwrite[1] = '{1'b1, v.a[4:0], v.c};
            end
            "X": begin
                // slot 1 is the next instruction of the pair
                slot[0] = '{v.a[0], v.b, v.a[2], v.a[1],
                            mips_pkg::exc_code_t'(v.c[4:0]), v.d};
                slot[1] = '{v.a[4], v.b + 32'd4, v.a[6], v.a[5],
                            mips_pkg::exc_code_t'(v.c[12:8]), v.d};
            end
            "H": hw_int = v.a[5:0];
            "E": is_eret = 1'b1;
            "T": begin
                cwrite[1] = '{1'b1, mips_pkg::CREG_COUNT, v.a};
                cwrite[0] = '{1'b1, mips_pkg::CREG_COMPARE, v.a + v.b};
            end
            default: ;
        endcase
    endtask

    initial begin
        reset  = 1'b1;
        hw_int = '0;
        ra     = '0;
        cur    = '0;
        clear_controls();
        void'($urandom(32'h2155));
        load_vectors();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (vecs[i]) begin
            @(negedge clk);
            cur         = vecs[i];
            timer_limit = 2 * int'(vecs[i].b) + 2;
            apply_vector(vecs[i]);
            vec_id = i + 1;
            @(negedge clk);
            clear_controls();
            wait (done_id == vec_id);
        end
        $display("%0d passed, %0d failed", pass_count, fail_count + load_errors);
        if (fail_count == 0 && load_errors == 0 && vecs.size() > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // 20 cycles per vector plus setup
    initial begin
        wait (loaded);
        repeat (vecs.size() * 20 + 200) @(posedge clk);
        $display("timeout: the vectors did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

/* flist.f */
design/mips_pkg.sv
design/cp0.sv
design/interrupt_ctrl.sv
design/exception_unit.sv
design/cp0_subsystem.sv
testbench/cp0_checker.sv
testbench/cp0_assertions.sv
testbench/cp0_tb.sv

/* run.sh */
#!/bin/sh
# build and run the CP0 testbench with Verilator
rm -rf obj_dir sim.log build.log
status=0

verilator --binary --timing --assert -Wno-fatal --top-module cp0_tb \
    -f flist.f -o cp0_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/cp0_sim > sim.log 2>&1 || status=1
cat sim.log

[ "$status" -eq 0 ] && ! grep -q "test failed" sim.log && exit 0 || exit 1

/* testbench/cp0_input.txt */
# kind a b c d ra0 ra1 | rd0 rd1 redirect_valid redirect_pc status cause cause_mask epc timer
# W: a=port b=addr c=data  D: a=addr b/c=data  X: a=slot flags b=pc c=codes d=badvaddr
W 0 b ffffffff 0 c e 0 0 0 0 0 0 8000007c 0 0
W 1 e 1000 0 b b ffffffff ffffffff 0 0 0 0 8000007c 1000 0
W 0 c ff03 0 e e 1000 1000 0 1000 ff03 0 8000007c 1000 0
W 1 c 0 0 c 1f ff03 0 0 1000 0 0 8000007c 1000 0
D e 2000 3000 0 c e 0 1000 0 1000 0 0 8000007c 2000 0
W 0 8 0 0 e 8 2000 0 0 2000 0 0 8000007c 2000 0
X 3 400 8 0 8 e 0 2000 1 bfc00380 2 20 8000007c 400 0
E 0 0 0 0 e c 400 2 1 400 0 20 8000007c 400 0
X 7 800 4 dead0001 e 8 400 0 1 bfc00380 2 80000010 8000007c 7fc 0
X 30 900 c00 0 8 e dead0001 7fc 1 bfc00380 2 80000030 8000007c 7fc 0
E 0 0 0 0 c e 2 7fc 1 7fc 0 80000030 8000007c 7fc 0
X 33 a00 90a 0 c e 0 7fc 1 bfc00380 2 28 8000007c a00 0
E 0 0 0 0 e e a00 a00 1 a00 0 28 8000007c a00 0
W 0 c 401 0 c e 0 a00 0 a00 401 28 8000007c a00 0
H 2 0 0 0 c e 401 a00 0 a00 401 28 8000007c a00 0
X 3 b00 9 0 c e 401 a00 1 bfc00380 403 24 8000007c b00 0
E 0 0 0 0 e e b00 b00 1 b00 401 24 8000007c b00 0
H 1 0 0 0 c e 401 b00 0 b00 401 24 8000007c b00 0
X 33 c00 80c 0 c e 401 b00 1 bfc00380 403 0 8000007c c00 0
H 0 0 0 0 e e c00 c00 0 c00 403 0 8000007c c00 0
E 0 0 0 0 c c 403 403 1 c00 401 0 8000007c c00 0
T 100 8 0 0 c e 401 c00 0 c00 0 0 0 0 0
W 0 b ffffffff 0 b e 108 c00 0 c00 401 0 8000007c c00 0
